//--- tcb_lite_config.svh
// bus geometry and address map shared by every file of the subsystem
// widths are in bits; TCB_DAT_W must be a multiple of 8
// region bases are unsized and are resized to TCB_ADR_W where used
// port 0 is the RAM and port 1 the GPIO block

`ifndef TCB_LITE_CONFIG_SVH
`define TCB_LITE_CONFIG_SVH

// bus widths
`define TCB_ADR_W 16
`define TCB_DAT_W 32
`define TCB_BYT_W (`TCB_DAT_W/8)

// subordinate port count and select width
`define TCB_IFN   2
`define TCB_SEL_W $clog2(`TCB_IFN)

// RAM region, port 0
`define TCB_MEM_BASE 'h0000
`define TCB_MEM_MASK 'hF000

// GPIO region, port 1
`define TCB_GPIO_BASE 'h8000
`define TCB_GPIO_MASK 'hF000

// subordinate sizes
`define TCB_MEM_DEPTH 256
`define TCB_GPIO_W    16

`endif

//--- tcb_lite_pkg.sv
// request, response and select types of the TCB-lite bus
// field widths come from the config header
// no lock, endianness or transfer size fields

`default_nettype none

`include "tcb_lite_config.svh"

package tcb_lite_pkg;

    //////////////////////////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////////////////////////

    // manager to subordinate payload
    // held stable by the manager while vld is high and rdy is low
    typedef struct packed {
        // write enable, low for a read
        logic                   wen;
        // byte address
        logic [`TCB_ADR_W-1:0]  adr;
        // byte enables, one per data byte
        logic [`TCB_BYT_W-1:0]  byt;
        // write data
        logic [`TCB_DAT_W-1:0]  wdt;
    } tcb_req_t;

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    // subordinate to manager payload
    // valid only in the cycle after a transfer
    typedef struct packed {
        // read data
        logic [`TCB_DAT_W-1:0]  rdt;
        // bus error
        logic                   err;
    } tcb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // select
    //////////////////////////////////////////////////////////////////////

    // subordinate port index, from the decoder
    typedef logic [`TCB_SEL_W-1:0] tcb_sel_t;

endpackage: tcb_lite_pkg

`default_nettype wire

//--- tcb_lite_lib_decoder.sv
// combinational address decoder, address to subordinate port
// regions are base/mask pairs checked in port order, first match wins
// an address in no region goes to the GPIO port, which answers with err

`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_config.svh"

module tcb_lite_lib_decoder (
    // request address
    input  wire logic [`TCB_ADR_W-1:0] adr,
    // subordinate port select
    output tcb_lite_pkg::tcb_sel_t     sel
);

    //////////////////////////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////////////////////////

    localparam int ADR_W = `TCB_ADR_W;

    // index of the fallback port for unmapped addresses
    localparam int GPIO_IDX = 1;

    // region table, one entry per port
    localparam logic [ADR_W-1:0] REG_BASE [`TCB_IFN] = '{
        ADR_W'(`TCB_MEM_BASE),
        ADR_W'(`TCB_GPIO_BASE)
    };
    localparam logic [ADR_W-1:0] REG_MASK [`TCB_IFN] = '{
        ADR_W'(`TCB_MEM_MASK),
        ADR_W'(`TCB_GPIO_MASK)
    };

    //////////////////////////////////////////////////////////////////////
    // priority match
    //////////////////////////////////////////////////////////////////////

    // walk from the last region down
    // so the lowest matching index is what remains
    always_comb begin
        sel = tcb_lite_pkg::tcb_sel_t'(GPIO_IDX);
        for (int i = `TCB_IFN-1; i >= 0; i--) begin
            if ((adr & REG_MASK[i]) == REG_BASE[i]) begin
                sel = tcb_lite_pkg::tcb_sel_t'(i);
            end
        end
    end

    // select must name an existing port
    // sampled on every change of the select
    sel_in_range: assert property (
        @(sel) int'(sel) <= `TCB_IFN-1
    ) else $error("decoder select %0d out of range", sel);

endmodule: tcb_lite_lib_decoder

`default_nettype wire

//--- tcb_lite_lib_demultiplexer.sv
// one manager port to TCB_IFN subordinate ports
// request is routed by the current select, response by the select
// stored at the transfer, so a new transfer may overlap the response
// fixed response delay of one cycle, no other delay supported

`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_config.svh"

module tcb_lite_lib_demultiplexer (
    input  wire logic                    sub,
    input  wire logic                    reset,
    // port select from the decoder
    input  tcb_lite_pkg::tcb_sel_t       sel,
    // manager side
    input  wire logic                    vld,
    input  tcb_lite_pkg::tcb_req_t       req,
    output logic                         rdy,
    output tcb_lite_pkg::tcb_rsp_t       rsp,
    // subordinate side
    output logic [`TCB_IFN-1:0]          man_vld,
    output tcb_lite_pkg::tcb_req_t [`TCB_IFN-1:0] man_req,
    input  wire logic [`TCB_IFN-1:0]     man_rdy,
    input  tcb_lite_pkg::tcb_rsp_t [`TCB_IFN-1:0] man_rsp
);

    // transfer on this edge
    logic                   trn;
    // select of the transfer whose response is due
    tcb_lite_pkg::tcb_sel_t rsp_sel;

    //////////////////////////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////////////////////////

    // payload goes to every port
    // valid only to the selected one
    always_comb begin
        for (int i = 0; i < `TCB_IFN; i++) begin
            man_vld[i] = vld && (sel == tcb_lite_pkg::tcb_sel_t'(i));
            man_req[i] = req;
        end
    end

    // ready of the port being addressed now
    assign rdy = man_rdy[sel];

    assign trn = vld && rdy;

    //////////////////////////////////////////////////////////////////////
    // response path
    //////////////////////////////////////////////////////////////////////

    // remember where the last transfer went
    always_ff @(posedge sub) begin
        if (reset) begin
            rsp_sel <= '0;
        end else if (trn) begin
            rsp_sel <= sel;
        end
    end

    // response of the port that took the previous transfer
    assign rsp = man_rsp[rsp_sel];

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // stored select moves only on the edge after a transfer
    rsp_sel_on_trn: assert property (
        @(posedge sub) disable iff (reset)
        !$past(trn) && !$past(reset) |-> $stable(rsp_sel)
    ) else $error("response select changed without a transfer");

    // manager holds the request while a subordinate stalls
    req_held: assert property (
        @(posedge sub) disable iff (reset)
        vld && !rdy |=> $stable(req)
    ) else $error("request changed while waiting for ready");

endmodule: tcb_lite_lib_demultiplexer

`default_nettype wire

//--- tcb_lite_mem.sv
// word RAM subordinate with byte enables
// one cycle from transfer to response, never stalls after reset
// word index is the address above the byte offset, modulo TCB_MEM_DEPTH
// write responses return zero read data, err is always zero

`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_config.svh"

module tcb_lite_mem (
    input  wire logic              sub,
    input  wire logic              reset,
    // subordinate port
    input  wire logic              vld,
    input  tcb_lite_pkg::tcb_req_t req,
    output logic                   rdy,
    output tcb_lite_pkg::tcb_rsp_t rsp
);

    // byte offset bits and word index bits
    localparam int OFF_W = $clog2(`TCB_BYT_W);
    localparam int IDX_W = $clog2(`TCB_MEM_DEPTH);

    // storage
    logic [`TCB_DAT_W-1:0] mem [`TCB_MEM_DEPTH];

    logic                  trn;
    logic [IDX_W-1:0]      idx;
    // registered read data
    logic [`TCB_DAT_W-1:0] rdt_q;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    // low in reset, high from the first cycle after it
    always_ff @(posedge sub) begin
        if (reset) begin
            rdy <= 1'b0;
        end else begin
            rdy <= 1'b1;
        end
    end

    assign trn = vld && rdy;

    // upper address bits beyond the array wrap around
    assign idx = req.adr[OFF_W +: IDX_W];

    //////////////////////////////////////////////////////////////////////
    // array access
    //////////////////////////////////////////////////////////////////////

    // byte lane writes
    always_ff @(posedge sub) begin
        if (trn && req.wen) begin
            for (int b = 0; b < `TCB_BYT_W; b++) begin
                if (req.byt[b]) begin
                    mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    // read data lands in the response cycle
    always_ff @(posedge sub) begin
        if (trn) begin
            rdt_q <= req.wen ? '0 : mem[idx];
        end
    end

    assign rsp.rdt = rdt_q;
    // every word is backed, nothing to flag
    assign rsp.err = 1'b0;

endmodule: tcb_lite_mem

`default_nettype wire

//--- tcb_lite_gpio.sv
// GPIO register subordinate, one wait state per request
// offset 0x0 output register r/w with byte enables, 0x4 input register r/o
// gpio_in goes through a two-stage synchronizer before it is readable
// any other address, or a write to 0x4, gives err with zero read data
// write responses return zero read data

`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_config.svh"

module tcb_lite_gpio (
    input  wire logic                   sub,
    input  wire logic                   reset,
    // subordinate port
    input  wire logic                   vld,
    input  tcb_lite_pkg::tcb_req_t      req,
    output logic                        rdy,
    output tcb_lite_pkg::tcb_rsp_t      rsp,
    // pins
    input  wire logic [`TCB_GPIO_W-1:0] gpio_in,
    output logic      [`TCB_GPIO_W-1:0] gpio_out
);

    localparam int ADR_W  = `TCB_ADR_W;
    localparam int GPIO_B = `TCB_GPIO_W/8;

    localparam logic [ADR_W-1:0] BASE = ADR_W'(`TCB_GPIO_BASE);
    localparam logic [ADR_W-1:0] MASK = ADR_W'(`TCB_GPIO_MASK);

    // two flop synchronizer
    logic [`TCB_GPIO_W-1:0] gpio_meta;
    logic [`TCB_GPIO_W-1:0] gpio_sync;

    logic                   wait_q;
    logic                   trn;
    // offset decode
    logic                   in_region;
    logic [ADR_W-1:0]       off;
    logic                   hit_out;
    logic                   hit_in;
    logic                   err_d;
    logic [`TCB_DAT_W-1:0]  rdt_d;

    //////////////////////////////////////////////////////////////////////
    // wait state
    //////////////////////////////////////////////////////////////////////

    // set in the first valid cycle, cleared by the transfer
    always_ff @(posedge sub) begin
        if (reset) begin
            wait_q <= 1'b0;
        end else if (trn) begin
            wait_q <= 1'b0;
        end else if (vld) begin
            wait_q <= 1'b1;
        end
    end

    assign rdy = wait_q;
    assign trn = vld && rdy;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    // unmapped addresses land here too, hence the region check
    assign in_region = (req.adr & MASK) == BASE;
    assign off       = req.adr & ~MASK;
    assign hit_out   = in_region && (off == ADR_W'('h0));
    assign hit_in    = in_region && (off == ADR_W'('h4));

    assign err_d = !(hit_out || hit_in) || (hit_in && req.wen);

    always_comb begin
        rdt_d = '0;
        if (!req.wen && hit_out) begin
            rdt_d = {{(`TCB_DAT_W-`TCB_GPIO_W){1'b0}}, gpio_out};
        end else if (!req.wen && hit_in) begin
            rdt_d = {{(`TCB_DAT_W-`TCB_GPIO_W){1'b0}}, gpio_sync};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        gpio_meta <= gpio_in;
        gpio_sync <= gpio_meta;
    end

    // output pins, byte lanes above the pin width ignored
    always_ff @(posedge sub) begin
        if (reset) begin
            gpio_out <= '0;
        end else if (trn && req.wen && hit_out) begin
            for (int b = 0; b < GPIO_B; b++) begin
                if (req.byt[b]) begin
                    gpio_out[8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    // response
    always_ff @(posedge sub) begin
        if (reset) begin
            rsp.err <= 1'b0;
        end else if (trn) begin
            rsp.err <= err_d;
        end
    end

    always_ff @(posedge sub) begin
        if (trn) begin
            rsp.rdt <= rdt_d;
        end
    end

    // every request spends one cycle stalled
    one_wait_state: assert property (
        @(posedge sub) disable iff (reset)
        vld && rdy |=> !(vld && rdy)
    ) else $error("gpio ready high twice in a row");

endmodule: tcb_lite_gpio

`default_nettype wire

//--- tcb_lite_top.sv
// TCB-lite subsystem, one manager port and two subordinates
// port 0 RAM, port 1 GPIO plus the error response for unmapped addresses
// response one cycle after each transfer, two transfers may be in flight

`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_config.svh"

module tcb_lite_top (
    input  wire logic                   sub,
    input  wire logic                   reset,
    // manager port
    input  wire logic                   vld,
    input  tcb_lite_pkg::tcb_req_t      req,
    output logic                        rdy,
    output tcb_lite_pkg::tcb_rsp_t      rsp,
    // pins
    input  wire logic [`TCB_GPIO_W-1:0] gpio_in,
    output logic      [`TCB_GPIO_W-1:0] gpio_out
);

    localparam int MEM_PORT  = 0;
    localparam int GPIO_PORT = 1;

    tcb_lite_pkg::tcb_sel_t                      sel;
    logic                   [`TCB_IFN-1:0]       man_vld;
    tcb_lite_pkg::tcb_req_t [`TCB_IFN-1:0]       man_req;
    logic                   [`TCB_IFN-1:0]       man_rdy;
    tcb_lite_pkg::tcb_rsp_t [`TCB_IFN-1:0]       man_rsp;

    // address to port
    tcb_lite_lib_decoder u_dec (
        .adr (req.adr),
        .sel (sel)
    );

    tcb_lite_lib_demultiplexer u_demux (
        .sub     (sub),
        .reset   (reset),
        .sel     (sel),
        .vld     (vld),
        .req     (req),
        .rdy     (rdy),
        .rsp     (rsp),
        .man_vld (man_vld),
        .man_req (man_req),
        .man_rdy (man_rdy),
        .man_rsp (man_rsp)
    );

    // subordinates
    tcb_lite_mem u_mem (
        .sub   (sub),
        .reset (reset),
        .vld   (man_vld[MEM_PORT]),
        .req   (man_req[MEM_PORT]),
        .rdy   (man_rdy[MEM_PORT]),
        .rsp   (man_rsp[MEM_PORT])
    );

    tcb_lite_gpio u_gpio (
        .sub      (sub),
        .reset    (reset),
        .vld      (man_vld[GPIO_PORT]),
        .req      (man_req[GPIO_PORT]),
        .rdy      (man_rdy[GPIO_PORT]),
        .rsp      (man_rsp[GPIO_PORT]),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule: tcb_lite_top

`default_nettype wire

//--- tcb_lite_tb.sv
// self-checking testbench for the TCB-lite subsystem
// stimulus and expected responses come from tcb_lite_vectors.txt
// inputs change on the falling edge, rdy and rsp are read in the low phase
// stops at the first mismatch, a cycle counter guards against hangs

`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_config.svh"

module tcb_lite_tb;

    localparam int ADR_W  = `TCB_ADR_W;
    localparam int GPIO_B = `TCB_GPIO_W/8;

    // one line of the vector file
    typedef struct packed {
        tcb_lite_pkg::tcb_req_t req;
        logic [`TCB_GPIO_W-1:0] gpio;
        logic [1:0]             idle;
        tcb_lite_pkg::tcb_rsp_t rsp;
    } vector_t;

    // one response still owed by the DUT
    typedef struct packed {
        tcb_lite_pkg::tcb_req_t req;
        tcb_lite_pkg::tcb_rsp_t rsp;
    } expect_t;

    logic                   sub;
    logic                   reset;
    logic                   vld;
    tcb_lite_pkg::tcb_req_t req;
    logic                   rdy;
    tcb_lite_pkg::tcb_rsp_t rsp;
    logic [`TCB_GPIO_W-1:0] gpio_in;
    logic [`TCB_GPIO_W-1:0] gpio_out;

    vector_t                vec_q [$];
    expect_t                exp_q [$];
    logic [`TCB_GPIO_W-1:0] gpio_shadow;
    int                     cycle_count;
    int                     cycle_limit;

    tcb_lite_top UUT (
        .sub      (sub),
        .reset    (reset),
        .vld      (vld),
        .req      (req),
        .rdy      (rdy),
        .rsp      (rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    // 4 ns period
    always #2 sub = ~sub;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        stop_with_failure();
    endtask

    // RAM region never stalls, everything else lands on the GPIO port
    function automatic logic is_ram(input logic [ADR_W-1:0] adr);
        return (adr & ADR_W'(`TCB_MEM_MASK)) == ADR_W'(`TCB_MEM_BASE);
    endfunction

    // output register at offset 0 of the GPIO region
    function automatic logic is_gpio_out(input logic [ADR_W-1:0] adr);
        return ((adr & ADR_W'(`TCB_GPIO_MASK)) == ADR_W'(`TCB_GPIO_BASE))
            && ((adr & ~ADR_W'(`TCB_GPIO_MASK)) == '0);
    endfunction

    task automatic load_vectors();
        int          fd;
        int          rc;
        int          n;
        int          f_idle;
        logic        bad_line;
        string       line;
        logic [31:0] f_wen;
        logic [31:0] f_adr;
        logic [31:0] f_byt;
        logic [31:0] f_wdt;
        logic [31:0] f_gin;
        logic [31:0] f_rdt;
        logic [31:0] f_err;
        vector_t     v;
        bad_line = 1'b0;
        fd = $fopen("tcb_lite_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tcb_lite_vectors.txt");
            stop_with_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                // skip comments and blank lines
                if (rc != 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %d %h %h", f_wen, f_adr,
                                f_byt, f_wdt, f_gin, f_idle, f_rdt, f_err);
                    if (n == 8) begin
                        v.req.wen = f_wen[0];
                        v.req.adr = f_adr[ADR_W-1:0];
                        v.req.byt = f_byt[`TCB_BYT_W-1:0];
                        v.req.wdt = f_wdt[`TCB_DAT_W-1:0];
                        v.gpio    = f_gin[`TCB_GPIO_W-1:0];
                        v.idle    = f_idle[1:0];
                        v.rsp.rdt = f_rdt[`TCB_DAT_W-1:0];
                        v.rsp.err = f_err[0];
                        vec_q.push_back(v);
                    end else begin
                        bad_line = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (bad_line || vec_q.size() == 0) begin
                $display("vector file has a malformed line or no vectors");
                stop_with_failure();
            end else begin
                // at most 2 idle plus 2 GPIO cycles per vector
                cycle_limit = vec_q.size() * 4 + 50;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        sub         = 1'b0;
        reset       = 1'b1;
        vld         = 1'b0;
        req         = '0;
        gpio_in     = '0;
        gpio_shadow = '0;
        cycle_count = 0;
        cycle_limit = 0;
        load_vectors();
        repeat (8) @(negedge sub);
        reset = 1'b0;
        // RAM ready rises one edge after reset
        repeat (2) @(negedge sub);
        foreach (vec_q[i]) begin
            int      waits;
            expect_t e;
            gpio_in = vec_q[i].gpio;
            repeat (vec_q[i].idle) begin
                vld = 1'b0;
                @(negedge sub);
            end
            vld   = 1'b1;
            req   = vec_q[i].req;
            waits = 0;
            #1;
            // hold the request while stalled
            while (!rdy) begin
                @(negedge sub);
                #1;
                waits++;
            end
            assert (waits == (is_ram(req.adr) ? 0 : 1))
            else report_mismatch("rdy wait cycles", is_ram(req.adr) ? 0 : 1, waits);
            // transfer on the coming rising edge
            e.req = vec_q[i].req;
            e.rsp = vec_q[i].rsp;
            exp_q.push_back(e);
            @(negedge sub);
        end
        vld = 1'b0;
        #1;
        while (exp_q.size() != 0) begin
            @(negedge sub);
            #1;
        end
        $display("Result: PASSED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // response check, low phase after the transfer edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge sub) begin : check_rsp
        expect_t e;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            assert (rsp.err === e.rsp.err)
            else report_mismatch("rsp.err", 32'(e.rsp.err), 32'(rsp.err));
            assert (rsp.rdt === e.rsp.rdt)
            else report_mismatch("rsp.rdt", 32'(e.rsp.rdt), 32'(rsp.rdt));
            // pins follow writes to the output register
            if (e.req.wen && is_gpio_out(e.req.adr)) begin
                for (int b = 0; b < GPIO_B; b++) begin
                    if (e.req.byt[b]) begin
                        gpio_shadow[8*b +: 8] = e.req.wdt[8*b +: 8];
                    end
                end
            end
        end
        if (!reset) begin
            assert (gpio_out === gpio_shadow)
            else report_mismatch("gpio_out", 32'(gpio_shadow), 32'(gpio_out));
        end
    end

    // hang guard
    always @(posedge sub) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run hung waiting for ready or a response after %0d cycles",
                     cycle_count);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- tcb_lite_vectors.txt
# wen adr byt wdt gpio_in idle exp_rdt exp_err, one transfer per line
# all fields hex except idle, the decimal count of idle cycles before the request
# RAM full word write, read back
1 0010 F DEADBEEF 0000 2 00000000 0
0 0010 0 00000000 0000 0 DEADBEEF 0
# byte lanes 0 and 2 only
1 0010 5 11223344 0000 1 00000000 0
0 0010 0 00000000 0000 0 DE22BE44 0
1 0104 F 0BADF00D 0000 1 00000000 0
# index wraps modulo the RAM depth
0 0410 0 00000000 0000 0 DE22BE44 0
# GPIO output register
1 8000 F 0000A5C3 0000 2 00000000 0
0 8000 0 00000000 0000 0 0000A5C3 0
1 8000 2 00007E00 0000 1 00000000 0
0 8000 0 00000000 0000 0 00007EC3 0
# GPIO input register and error responses
0 8004 0 00000000 1234 2 00001234 0
1 8004 F FFFFFFFF 1234 0 00000000 1
0 800C 0 00000000 1234 1 00000000 1
0 4000 0 00000000 1234 0 00000000 1
1 4000 F 12345678 1234 0 00000000 1
# interleaved RAM and GPIO, no idle cycles
0 8000 0 00000000 1234 1 00007EC3 0
0 0104 0 00000000 1234 0 0BADF00D 0
0 8004 0 00000000 1234 0 00001234 0
0 0010 0 00000000 1234 0 DE22BE44 0
0 0104 0 00000000 1234 0 0BADF00D 0
1 800C F 00000001 1234 0 00000000 1
0 0010 0 00000000 1234 0 DE22BE44 0
0 8004 0 00000000 BEEF 2 0000BEEF 0
1 03FC F CAFEF00D BEEF 0 00000000 0
0 03FC 0 00000000 BEEF 0 CAFEF00D 0

//--- verilog.f
+incdir+.
tcb_lite_pkg.sv
tcb_lite_lib_decoder.sv
tcb_lite_lib_demultiplexer.sv
tcb_lite_mem.sv
tcb_lite_gpio.sv
tcb_lite_top.sv
tcb_lite_tb.sv

//--- Bender.yml
package:
  name: tcb_lite

export_include_dirs:
  - .

sources:
  - tcb_lite_pkg.sv
  - tcb_lite_lib_decoder.sv
  - tcb_lite_lib_demultiplexer.sv
  - tcb_lite_mem.sv
  - tcb_lite_gpio.sv
  - tcb_lite_top.sv
  - target: simulation
    files:
      - tcb_lite_tb.sv
